/* sources.f */
+incdir+.
shuffle_pkg.sv
shuffle_instr_class.sv
shuffle_branch_guard.sv
shuffle_rename_map.sv
shuffle_entry_pick.sv
shuffle_buffer.sv
tb_shuffle_checker.sv
tb_shuffle_props.sv
tb_shuffle.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_shuffle
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_shuffle.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shuffle_consts.svh"

module tb_shuffle
  import shuffle_pkg::*;
();

  logic   clk_i = 1'b0;
  logic   rst_ni, fetch_valid_i, branch_i, ready_i;
  logic   fetch_ready_o, valid_o;
  instr_t fetch_instr_i;
  pc_t    fetch_pc_i;
  issue_t issue_o;
  int     err_cnt, taken, issued_cnt;

  pc_t    tbl_pc    [64];  // stimulus rows
  instr_t tbl_instr [64];
  logic   tbl_stall [64];  // hold fetch_valid_i low one cycle before the row
  int     n_rows = 0;
  int     cycles = 0;

  always #4 clk_i = ~clk_i;

  shuffle_buffer shuffle_buffer_inst (.*);

  tb_shuffle_checker tb_shuffle_checker_inst (
    .clk_i, .rst_ni, .fetch_valid_i, .fetch_instr_i, .fetch_pc_i,
    .fetch_ready_i (fetch_ready_o),
    .branch_i, .ready_i,
    .valid_i   (valid_o),
    .issue_i   (issue_o),
    .err_cnt_o (err_cnt),
    .taken_o   (taken),
    .issued_o  (issued_cnt)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
  endfunction

  function automatic instr_t enc_addi(input lreg_t rd, input lreg_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic instr_t enc_add(input lreg_t rd, input lreg_t rs1, input lreg_t rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, `SHUF_OPC_OP};
  endfunction

  function automatic instr_t enc_lw(input lreg_t rd, input lreg_t rs1);
    return {12'h0, rs1, 3'b010, rd, `SHUF_OPC_LOAD};
  endfunction

  function automatic instr_t enc_sw(input lreg_t rs2, input lreg_t rs1);
    return {7'b0, rs2, rs1, 3'b010, 5'b0, `SHUF_OPC_STORE};
  endfunction

  function automatic instr_t enc_jal(input lreg_t rd);
    return {20'h0, rd, `SHUF_OPC_JAL};
  endfunction

  task automatic add_row(input pc_t pc, input instr_t w, input logic stall);
    tbl_pc[n_rows] = pc;
    tbl_instr[n_rows] = w;
    tbl_stall[n_rows] = stall;
    n_rows++;
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (n_rows > 0 && cycles > n_rows * 40) begin
      $display("timeout after %0d cycles, %0d taken, %0d issued", cycles, taken, issued_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin : drive
    logic [31:0] rnd;
    logic        took, fire, redirect, held, b0, b1;
    int          idx;
    rst_ni = 1'b0;
    {fetch_valid_i, branch_i, ready_i} = '0;
    fetch_instr_i = '0;
    fetch_pc_i = '0;
    rnd = 32'hd15ad30a;
    idx = 0;
    held = 1'b0;
    // program 0, alu chain with a store/load pair
    add_row(32'h000, enc_addi(5'd1, 5'd0, 12'd5), 1'b0);
    add_row(32'h004, enc_addi(5'd2, 5'd1, 12'd3), 1'b0);
    add_row(32'h008, enc_add(5'd3, 5'd1, 5'd2), 1'b0);
    add_row(32'h00c, enc_sw(5'd3, 5'd2), 1'b0);
    add_row(32'h010, enc_lw(5'd4, 5'd1), 1'b1);
    add_row(32'h014, enc_add(5'd5, 5'd4, 5'd3), 1'b0);
    add_row(32'h018, enc_jal(5'd0), 1'b0);
    // program 1, memory ordering and rd overwrite
    add_row(32'h100, enc_lw(5'd6, 5'd2), 1'b0);
    add_row(32'h104, enc_sw(5'd6, 5'd3), 1'b0);
    add_row(32'h108, enc_lw(5'd7, 5'd6), 1'b0);
    add_row(32'h10c, enc_addi(5'd1, 5'd7, 12'd1), 1'b1);
    add_row(32'h110, enc_add(5'd1, 5'd1, 5'd1), 1'b0);
    add_row(32'h114, enc_jal(5'd1), 1'b0);
    // program 2, ecall in the middle, write to x0
    add_row(32'h200, enc_addi(5'd8, 5'd0, 12'd1), 1'b0);
    add_row(32'h204, enc_addi(5'd9, 5'd8, 12'd2), 1'b0);
    add_row(32'h208, 32'h00000073, 1'b0);
    add_row(32'h20c, enc_add(5'd10, 5'd9, 5'd8), 1'b0);
    add_row(32'h210, enc_addi(5'd0, 5'd1, 12'd1), 1'b0);
    add_row(32'h214, enc_jal(5'd0), 1'b0);
    // program 3, ecall before the last jal drains the buffer
    add_row(32'h300, enc_add(5'd11, 5'd10, 5'd9), 1'b0);
    add_row(32'h304, enc_sw(5'd11, 5'd10), 1'b0);
    add_row(32'h308, enc_lw(5'd12, 5'd11), 1'b1);
    add_row(32'h30c, enc_add(5'd2, 5'd12, 5'd2), 1'b0);
    add_row(32'h310, 32'h00000073, 1'b0);
    add_row(32'h314, enc_jal(5'd0), 1'b0);
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (!(idx == n_rows && issued_cnt == n_rows)) begin
      @(negedge clk_i);
      took = fetch_valid_i && fetch_ready_o;
      fire = valid_o && ready_i;
      redirect = fire && (issue_o.instr[6:0] inside {`SHUF_OPC_JAL, `SHUF_OPC_SYSTEM});
      @(posedge clk_i);
      if (took) begin
        idx++;
        held = 1'b0;
      end
      rnd = lfsr_step(rnd);
      b0 = rnd[0];
      rnd = lfsr_step(rnd);
      b1 = rnd[0];
      branch_i <= redirect;          // consumer redirects after a jal or ecall
      ready_i <= redirect ? 1'b0 : (b0 | b1);
      if (idx < n_rows && !(tbl_stall[idx] && !held)) begin
        fetch_valid_i <= 1'b1;
        fetch_pc_i <= tbl_pc[idx];
        fetch_instr_i <= tbl_instr[idx];
      end else begin
        fetch_valid_i <= 1'b0;
        held = idx < n_rows;         // stall row now shown after one idle cycle
      end
    end
    repeat (4) @(posedge clk_i);
    $display("%0d rows, %0d taken, %0d issued, %0d errors", n_rows, taken, issued_cnt, err_cnt);
    if (err_cnt == 0 && taken == n_rows && issued_cnt == n_rows) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_shuffle_props.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_shuffle_props
  import shuffle_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      branch_i,
  input logic      valid_o,
  input logic      fetch_ready_o,
  input logic      take_i,         // internal take handshake of the buffer
  input logic      issue_fire_i,
  input slot_vec_t valid_slots_i,  // entry valid bits
  input slot_vec_t ready_slots_i,  // valid and no open dependency
  input slot_t     rm_slot_i,
  input slot_t     ins_slot_i
);

  // redirect cycle blocks both sides
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_i |-> !valid_o && !fetch_ready_o)
    else $error("valid_o or fetch_ready_o high during branch_i");

  // offered entry is live and waits for nobody
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> ready_slots_i[rm_slot_i])
    else $error("valid_o high for an empty or still waiting entry");

  // new instruction lands in an empty slot unless it reuses the issued one
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    take_i && !issue_fire_i |-> !valid_slots_i[ins_slot_i])
    else $error("take overwrites a valid entry");

endmodule

bind shuffle_buffer tb_shuffle_props tb_shuffle_props_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .branch_i      (branch_i),
  .valid_o       (valid_o),
  .fetch_ready_o (fetch_ready_o),
  .take_i        (take),
  .issue_fire_i  (issue_fire),
  .valid_slots_i (valid_q),
  .ready_slots_i (ready_slots),
  .rm_slot_i     (rm_slot),
  .ins_slot_i    (ins_slot)
);

`default_nettype wire

/* tb_shuffle_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shuffle_consts.svh"

module tb_shuffle_checker
  import shuffle_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_valid_i,
  input  instr_t fetch_instr_i,
  input  pc_t    fetch_pc_i,
  input  logic   fetch_ready_i,
  input  logic   branch_i,
  input  logic   ready_i,
  input  logic   valid_i,
  input  issue_t issue_i,
  output int     err_cnt_o,
  output int     taken_o,
  output int     issued_o
);

  localparam int MaxIds = 64;

  preg_t       map [`SHUF_NUM_LREGS];  // model of logical -> physical
  int          last_wr [`SHUF_NUM_LREGS];  // newest taken writer of each register, -1 for none
  preg_vec_t   reserved;
  pc_t         e_pc    [MaxIds];       // indexed by take order
  instr_t      e_instr [MaxIds];
  rename_t     e_ren   [MaxIds];
  logic        e_mem   [MaxIds];
  logic        e_live  [MaxIds];       // taken, not yet issued
  logic [MaxIds-1:0] e_dep [MaxIds];   // older ids this one waits for
  int          prog_left [16];
  logic        prog_end  [16];         // closing jal of the program was taken
  logic        gated;
  logic        nt_armed;               // branch pc went out last cycle
  pc_t         gate_pc;

  // class flags straight from the rv32 encoding rules
  function automatic instr_class_t classify(input instr_t w);
    instr_class_t c;
    logic [6:0]   op;
    logic [2:0]   f3;
    op = w[6:0];
    f3 = w[14:12];
    c.rd = w[11:7];
    c.rs1 = w[19:15];
    c.rs2 = w[24:20];
    c.is_sys = (op == `SHUF_OPC_SYSTEM) && (f3 == 3'd0);
    c.is_mem = (op == `SHUF_OPC_LOAD) || (op == `SHUF_OPC_STORE);
    c.has_rd = !((op == `SHUF_OPC_BRANCH) || (op == `SHUF_OPC_STORE)
               || (op == `SHUF_OPC_FENCE) || c.is_sys);
    c.has_rs1 = !((op == `SHUF_OPC_LUI) || (op == `SHUF_OPC_AUIPC) || (op == `SHUF_OPC_JAL)
                || (op == `SHUF_OPC_FENCE) || c.is_sys
                || ((op == `SHUF_OPC_SYSTEM) && (f3 inside {3'd5, 3'd6, 3'd7})));
    c.has_rs2 = (op == `SHUF_OPC_BRANCH) || (op == `SHUF_OPC_STORE) || (op == `SHUF_OPC_OP);
    c.changes_pc = (op == `SHUF_OPC_JAL) || (op == `SHUF_OPC_JALR) || (op == `SHUF_OPC_BRANCH)
                || (op == `SHUF_OPC_FENCE) || c.is_sys;
    return c;
  endfunction

  // lowest register neither mapped nor named by a buffered instruction
  function automatic preg_t lowest_free();
    preg_vec_t used;
    preg_t     p;
    used = reserved;
    for (int j = 0; j < MaxIds; j++) begin
      if (e_live[j]) begin
        used[e_ren[j].rd_phys] = 1'b1;
        used[e_ren[j].rs1_phys] = 1'b1;
        used[e_ren[j].rs2_phys] = 1'b1;
      end
    end
    p = '0;
    for (int i = `SHUF_NUM_PREGS - 1; i >= 0; i--) begin
      if (!used[i]) p = preg_t'(i);
    end
    return p;
  endfunction

  task automatic compare(input string name, input pc_t pc, input logic [31:0] exp,
                         input logic [31:0] got);
    if (exp !== got) begin
      err_cnt_o++;
      $display("Fail %s at pc %h: expected %h, got %h", name, pc, exp, got);
    end
  endtask

  // sampled mid-cycle, inputs only move on the rising edge
  always @(negedge clk_i) begin : check_cycle
    instr_class_t c;
    rename_t      r;
    logic         take, fire, nt_now;
    int           hit, live_cnt, prog;
    if (!rst_ni) begin
      for (int i = 0; i < `SHUF_NUM_LREGS; i++) begin
        map[i] = preg_t'(i);
        last_wr[i] = -1;
      end
      reserved = {{(`SHUF_NUM_PREGS - `SHUF_NUM_LREGS){1'b0}}, {`SHUF_NUM_LREGS{1'b1}}};
      for (int j = 0; j < MaxIds; j++) e_live[j] = 1'b0;
      for (int j = 0; j < 16; j++) begin
        prog_left[j] = 0;
        prog_end[j] = 1'b0;
      end
      {gated, nt_armed, gate_pc} = '0;
      {err_cnt_o, taken_o, issued_o} = '0;
    end else begin
      take = fetch_valid_i && fetch_ready_i;
      fire = valid_i && ready_i;
      nt_now = nt_armed && ready_i;  // consumer fell through the branch
      live_cnt = 0;
      for (int j = 0; j < MaxIds; j++) live_cnt += int'(e_live[j]);
      if (take && gated && !nt_now) begin
        err_cnt_o++;
        $display("intake opened at pc %h while the branch at pc %h was unresolved",
                 fetch_pc_i, gate_pc);
      end
      if (fetch_ready_i && live_cnt == `SHUF_DEPTH && !fire) begin
        err_cnt_o++;
        $display("fetch_ready_o is high with a full buffer and no issue");
      end
      // prediction uses the state before this edge
      c = classify(fetch_instr_i);
      r.rs1_phys = c.has_rs1 ? map[c.rs1] : '0;
      r.rs2_phys = c.has_rs2 ? map[c.rs2] : '0;
      r.rd_phys = (c.has_rd && c.rd != '0) ? lowest_free() : '0;
      if (take) begin
        e_dep[taken_o] = '0;
        // memory keeps program order, ecall waits for everything older
        for (int j = 0; j < taken_o; j++) begin
          if ((e_mem[j] && c.is_mem) || c.is_sys) e_dep[taken_o][j] = 1'b1;
        end
        // a source waits for the newest older writer of its register
        if (c.has_rs1 && c.rs1 != '0 && last_wr[c.rs1] >= 0)
          e_dep[taken_o][last_wr[c.rs1]] = 1'b1;
        if (c.has_rs2 && c.rs2 != '0 && last_wr[c.rs2] >= 0)
          e_dep[taken_o][last_wr[c.rs2]] = 1'b1;
      end
      if (fire) begin
        hit = -1;
        for (int j = 0; j < MaxIds; j++) begin
          if (e_live[j] && e_pc[j] == issue_i.pc) hit = j;
        end
        if (hit < 0) begin
          err_cnt_o++;
          $display("pc %h issued but was never taken or already issued", issue_i.pc);
        end else begin
          compare("issue_o.instr", issue_i.pc, e_instr[hit], issue_i.instr);
          compare("issue_o.rd_phys", issue_i.pc, 32'(e_ren[hit].rd_phys), 32'(issue_i.rd_phys));
          compare("issue_o.rs1_phys", issue_i.pc, 32'(e_ren[hit].rs1_phys),
                  32'(issue_i.rs1_phys));
          compare("issue_o.rs2_phys", issue_i.pc, 32'(e_ren[hit].rs2_phys),
                  32'(issue_i.rs2_phys));
          for (int j = 0; j < MaxIds; j++) begin
            if (e_dep[hit][j] && e_live[j]) begin
              err_cnt_o++;
              $display("pc %h issued before older pc %h that it waits for", e_pc[hit], e_pc[j]);
            end
          end
          e_live[hit] = 1'b0;
          prog = int'(e_pc[hit][11:8]);
          prog_left[prog]--;
          if (prog_end[prog] && prog_left[prog] == 0)
            $display("program %0d done, %0d instructions taken, %0d errors so far",
                     prog, taken_o, err_cnt_o);
        end
        issued_o++;
      end
      if (take) begin
        e_pc[taken_o] = fetch_pc_i;
        e_instr[taken_o] = fetch_instr_i;
        e_ren[taken_o] = r;
        e_mem[taken_o] = c.is_mem;
        e_live[taken_o] = 1'b1;
        if (r.rd_phys != '0) begin
          reserved[map[c.rd]] = 1'b0;
          reserved[r.rd_phys] = 1'b1;
          map[c.rd] = r.rd_phys;
        end
        if (c.has_rd && c.rd != '0) last_wr[c.rd] = taken_o;
        prog = int'(fetch_pc_i[11:8]);
        prog_left[prog]++;
        if (fetch_instr_i[6:0] == `SHUF_OPC_JAL) prog_end[prog] = 1'b1;
        taken_o++;
      end
      nt_armed = fire && gated && (issue_i.pc == gate_pc);  // open branch went out
      if (branch_i || nt_now) gated = 1'b0;
      if (take && c.changes_pc) begin
        gated = 1'b1;  // set wins over clear
        gate_pc = fetch_pc_i;
      end
    end
  end

endmodule

`default_nettype wire

/* shuffle_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shuffle_consts.svh"

module shuffle_buffer
  import shuffle_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_valid_i,
  input  instr_t fetch_instr_i,
  input  pc_t    fetch_pc_i,
  output logic   fetch_ready_o,
  input  logic   branch_i,       // pulse, pc redirected by the consumer
  input  logic   ready_i,
  output logic   valid_o,
  output issue_t issue_o
);

  // entry storage
  slot_vec_t valid_q;
  pc_t       pc_q    [`SHUF_DEPTH];
  instr_t    instr_q [`SHUF_DEPTH];
  rename_t   ren_q   [`SHUF_DEPTH];
  preg_vec_t usage_q [`SHUF_DEPTH];  // physical regs named by the entry
  slot_vec_t mem_q;                  // entry is a load or store
  slot_vec_t dep_q   [`SHUF_DEPTH];  // row i: older entries that i waits for

  instr_class_t cls;
  rename_t      ren;
  slot_t        rm_slot, ins_slot;
  slot_vec_t    ready_slots, new_dep;
  preg_vec_t    slot_usage, new_usage;
  logic         discard, permit;
  logic         full, nonempty;
  logic         take, issue_fire;

  shuffle_instr_class shuffle_instr_class_inst (
    .instr_i (fetch_instr_i),
    .class_o (cls)
  );

  shuffle_rename_map shuffle_rename_map_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .take_i       (take),
    .class_i      (cls),
    .slot_usage_i (slot_usage),
    .ren_o        (ren)
  );

  shuffle_branch_guard shuffle_branch_guard_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .take_i       (take),
    .class_i      (cls),
    .fetch_pc_i   (fetch_pc_i),
    .issue_fire_i (issue_fire),
    .issue_pc_i   (issue_o.pc),
    .ready_i      (ready_i),
    .branch_i     (branch_i),
    .discard_o    (discard),
    .permit_o     (permit)
  );

  shuffle_entry_pick shuffle_entry_pick_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ready_slots_i (ready_slots),
    .valid_slots_i (valid_q),
    .issue_fire_i  (issue_fire),
    .remove_slot_o (rm_slot),
    .insert_slot_o (ins_slot)
  );

  assign full     = &valid_q;
  assign nonempty = |valid_q;

  // drain only when full, or when nothing more can come before the branch resolves
  assign valid_o       = (full || (nonempty && discard)) && !branch_i;
  assign issue_fire    = valid_o && ready_i;
  assign fetch_ready_o = !branch_i && permit && (!full || issue_fire);
  assign take          = fetch_valid_i && fetch_ready_o;

  always_comb begin
    issue_o.pc       = pc_q[rm_slot];
    issue_o.instr    = instr_q[rm_slot];
    issue_o.rd_phys  = ren_q[rm_slot].rd_phys;
    issue_o.rs1_phys = ren_q[rm_slot].rs1_phys;
    issue_o.rs2_phys = ren_q[rm_slot].rs2_phys;
  end

  always_comb begin
    slot_usage = '0;
    for (int i = 0; i < `SHUF_DEPTH; i++) begin
      ready_slots[i] = valid_q[i] && !(|dep_q[i]);
      slot_usage     = slot_usage | usage_q[i];  // usage is zero for empty entries
    end
    new_usage = (preg_vec_t'(1) << ren.rd_phys) | (preg_vec_t'(1) << ren.rs1_phys)
              | (preg_vec_t'(1) << ren.rs2_phys);
  end

  // dependency row of the incoming instruction
  always_comb begin
    for (int i = 0; i < `SHUF_DEPTH; i++) begin
      new_dep[i] = valid_q[i] && (
          ((ren_q[i].rd_phys != '0) && ((ren_q[i].rd_phys == ren.rs1_phys)
                                     || (ren_q[i].rd_phys == ren.rs2_phys)))
          || (mem_q[i] && cls.is_mem)   // memory stays in order
          || cls.is_sys);               // ecall/ebreak waits for all older
    end
    new_dep[ins_slot] = 1'b0;  // slot may be freed and refilled in the same cycle
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < `SHUF_DEPTH; i++) begin
        usage_q[i] <= '0;
        dep_q[i]   <= '0;
      end
    end else begin
      if (issue_fire) begin
        valid_q[rm_slot] <= 1'b0;
        usage_q[rm_slot] <= '0;
        for (int i = 0; i < `SHUF_DEPTH; i++) begin
          dep_q[i][rm_slot] <= 1'b0;  // release waiters
        end
      end
      // take after issue, so a reused slot ends up valid
      if (take) begin
        valid_q[ins_slot] <= 1'b1;
        usage_q[ins_slot] <= new_usage;
        dep_q[ins_slot]   <= new_dep;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      pc_q[ins_slot]    <= fetch_pc_i;
      instr_q[ins_slot] <= fetch_instr_i;
      ren_q[ins_slot]   <= ren;
      mem_q[ins_slot]   <= cls.is_mem;
    end
  end

endmodule

`default_nettype wire

/* shuffle_entry_pick.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shuffle_consts.svh"

module shuffle_entry_pick
  import shuffle_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  slot_vec_t ready_slots_i,  // valid and no open dependency
  input  slot_vec_t valid_slots_i,
  input  logic      issue_fire_i,
  output slot_t     remove_slot_o,
  output slot_t     insert_slot_o
);

  logic [15:0] lfsr_q;
  slot_t       rnd_col;                                  // column picked this cycle
  slot_t       dist_tbl [`SHUF_DEPTH][`SHUF_DEPTH];      // [distance rank][column]
  slot_vec_t   cand;                                     // readiness in distance order
  slot_t       first_rank;
  slot_t       free_slot;

  // random start, free running
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `SHUF_LFSR_SEED;
    end else if (lfsr_q[0]) begin
      lfsr_q <= (lfsr_q >> 1) ^ `SHUF_LFSR_TAPS;
    end else begin
      lfsr_q <= lfsr_q >> 1;
    end
  end

  // rows hold offsets 0, +1, -1, +2, -2 from the column, wrapping
  for (genvar r = 0; r < `SHUF_DEPTH; r++) begin : g_row
    localparam int step = (r == 0) ? 0 : ((r % 2 == 1) ? (r + 1) / 2 : -(r / 2));
    for (genvar c = 0; c < `SHUF_DEPTH; c++) begin : g_col
      assign dist_tbl[r][c] = slot_t'((c + `SHUF_DEPTH + step) % `SHUF_DEPTH);
    end
  end

  assign rnd_col = slot_t'(lfsr_q % 16'(`SHUF_DEPTH));

  // nearest ready entry to the random start
  always_comb begin
    for (int i = 0; i < `SHUF_DEPTH; i++) begin
      cand[i] = ready_slots_i[dist_tbl[i][rnd_col]];
    end
    first_rank = '0;
    for (int i = `SHUF_DEPTH - 1; i >= 0; i--) begin
      if (cand[i]) begin
        first_rank = slot_t'(i);
      end
    end
    remove_slot_o = dist_tbl[first_rank][rnd_col];
  end

  // lowest empty entry for the incoming instruction
  always_comb begin
    free_slot = '0;
    for (int i = `SHUF_DEPTH - 1; i >= 0; i--) begin
      if (!valid_slots_i[i]) begin
        free_slot = slot_t'(i);
      end
    end
    insert_slot_o = issue_fire_i ? remove_slot_o : free_slot;  // valid bits lag by a cycle
  end

endmodule

`default_nettype wire

/* shuffle_rename_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shuffle_consts.svh"

module shuffle_rename_map
  import shuffle_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         take_i,
  input  instr_class_t class_i,
  input  preg_vec_t    slot_usage_i,  // registers still named by buffered instructions
  output rename_t      ren_o
);

  preg_t     map_q [`SHUF_NUM_LREGS];  // logical -> physical
  preg_vec_t reserved_q;               // same content as map_q, one-hot per mapping
  preg_vec_t in_use;
  preg_t     first_free;
  logic      writes_rd;

  assign writes_rd = class_i.has_rd && (class_i.rd != '0);  // x0 is never renamed

  // lowest register that is neither mapped nor referenced by the buffer
  always_comb begin
    in_use     = reserved_q | slot_usage_i;
    first_free = '0;
    for (int i = `SHUF_NUM_PREGS - 1; i >= 0; i--) begin
      if (!in_use[i]) begin
        first_free = preg_t'(i);
      end
    end
  end

  // sources come from the map before this instruction's own update
  always_comb begin
    ren_o.rd_phys  = writes_rd ? first_free : '0;
    ren_o.rs1_phys = class_i.has_rs1 ? map_q[class_i.rs1] : '0;
    ren_o.rs2_phys = class_i.has_rs2 ? map_q[class_i.rs2] : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `SHUF_NUM_LREGS; i++) begin
        map_q[i] <= preg_t'(i);  // identity mapping
      end
      for (int i = 0; i < `SHUF_NUM_PREGS; i++) begin
        reserved_q[i] <= (i < `SHUF_NUM_LREGS);
      end
    end else if (take_i && writes_rd) begin
      // old mapping is released, first_free is never the old one
      reserved_q[map_q[class_i.rd]] <= 1'b0;
      reserved_q[first_free]        <= 1'b1;
      map_q[class_i.rd]             <= first_free;
    end
  end

endmodule

`default_nettype wire

/* shuffle_branch_guard.sv */
`timescale 1ns/1ps
`default_nettype none

module shuffle_branch_guard
  import shuffle_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         take_i,        // instruction enters the buffer this cycle
  input  instr_class_t class_i,       // class of the instruction on the fetch side
  input  pc_t          fetch_pc_i,
  input  logic         issue_fire_i,  // valid_o && ready_i
  input  pc_t          issue_pc_i,
  input  logic         ready_i,
  input  logic         branch_i,      // consumer has redirected the pc
  output logic         discard_o,
  output logic         permit_o
);

  logic discard_q;
  pc_t  branch_pc_q;      // pc of the last pc-changing instruction taken
  logic just_issued_q;    // that pc went out in the previous cycle
  logic not_taken;

  // consumer keeps ready_i up after a branch only when it fell through
  assign not_taken = just_issued_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      discard_q     <= 1'b0;
      just_issued_q <= 1'b0;
    end else begin
      // stored pc only counts while its branch is still open
      just_issued_q <= issue_fire_i && discard_q && (issue_pc_i == branch_pc_q);
      if (branch_i || not_taken) begin
        discard_q <= 1'b0;
      end
      // set wins over clear, back to back branches keep intake stopped
      if (take_i && class_i.changes_pc) begin
        discard_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_i && class_i.changes_pc) begin
      branch_pc_q <= fetch_pc_i;
    end
  end

  assign discard_o = discard_q;
  assign permit_o  = !discard_q || not_taken;  // skip the cycle the flag needs to drop

endmodule

`default_nettype wire

/* shuffle_instr_class.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shuffle_consts.svh"

module shuffle_instr_class
  import shuffle_pkg::*;
(
  input  instr_t       instr_i,
  output instr_class_t class_o
);

  logic [6:0] opc;
  logic [2:0] funct3;
  logic       is_system;
  logic       is_csr_imm;   // csrrwi / csrrsi / csrrci carry a zimm, not rs1

  assign opc        = instr_i[6:0];
  assign funct3     = instr_i[14:12];
  assign is_system  = (opc == `SHUF_OPC_SYSTEM);
  assign is_csr_imm = is_system && (funct3 inside {3'b101, 3'b110, 3'b111});

  always_comb begin
    // register fields sit at fixed positions in every format
    class_o.rd  = instr_i[11:7];
    class_o.rs1 = instr_i[19:15];
    class_o.rs2 = instr_i[24:20];

    class_o.is_sys = is_system && (funct3 == 3'b000);  // ecall / ebreak
    class_o.is_mem = (opc == `SHUF_OPC_LOAD) || (opc == `SHUF_OPC_STORE);

    // b-type, s-type, fence and ecall/ebreak write nothing
    class_o.has_rd = (opc != `SHUF_OPC_BRANCH) && (opc != `SHUF_OPC_STORE)
                  && (opc != `SHUF_OPC_FENCE) && !class_o.is_sys;

    class_o.has_rs1 = (opc != `SHUF_OPC_LUI) && (opc != `SHUF_OPC_AUIPC)
                   && (opc != `SHUF_OPC_JAL) && (opc != `SHUF_OPC_FENCE)
                   && !class_o.is_sys && !is_csr_imm;

    class_o.has_rs2 = (opc == `SHUF_OPC_BRANCH) || (opc == `SHUF_OPC_STORE)
                   || (opc == `SHUF_OPC_OP);

    // anything after which the next fetch pc is not known yet
    class_o.changes_pc = (opc == `SHUF_OPC_JAL) || (opc == `SHUF_OPC_JALR)
                      || (opc == `SHUF_OPC_BRANCH) || (opc == `SHUF_OPC_FENCE)
                      || class_o.is_sys;
  end

endmodule

`default_nettype wire

/* shuffle_pkg.sv */
`default_nettype none

package shuffle_pkg;

`include "shuffle_consts.svh"

  typedef logic [31:0]                  instr_t;     // uncompressed instruction word
  typedef logic [31:0]                  pc_t;
  typedef logic [4:0]                   lreg_t;      // x0..x31
  typedef logic [5:0]                   preg_t;      // physical register index
  typedef logic [`SHUF_NUM_PREGS-1:0]   preg_vec_t;  // one bit per physical register
  typedef logic [2:0]                   slot_t;      // buffer entry index
  typedef logic [`SHUF_DEPTH-1:0]       slot_vec_t;  // one bit per buffer entry

  // decoded operand fields and class of one instruction
  typedef struct packed {
    lreg_t rd;
    lreg_t rs1;
    lreg_t rs2;
    logic  has_rd;
    logic  has_rs1;
    logic  has_rs2;
    logic  changes_pc;  // may redirect fetch
    logic  is_mem;      // load or store
    logic  is_sys;      // ecall / ebreak
  } instr_class_t;

  // physical operands of one instruction
  typedef struct packed {
    preg_t rd_phys;   // 0 when there is no destination
    preg_t rs1_phys;
    preg_t rs2_phys;
  } rename_t;

  // what goes to decode/execute
  typedef struct packed {
    pc_t    pc;
    instr_t instr;
    preg_t  rd_phys;
    preg_t  rs1_phys;
    preg_t  rs2_phys;
  } issue_t;

endpackage

`default_nettype wire

/* shuffle_consts.svh */
`ifndef SHUFFLE_CONSTS_SVH
`define SHUFFLE_CONSTS_SVH

// buffer and register file sizes
`define SHUF_DEPTH       5   // shuffle buffer entries
`define SHUF_NUM_PREGS   64  // physical registers
`define SHUF_NUM_LREGS   32  // rv32 logical registers

// rv32 major opcodes, bits [6:0]
`define SHUF_OPC_JAL     7'b1101111
`define SHUF_OPC_JALR    7'b1100111
`define SHUF_OPC_BRANCH  7'b1100011
`define SHUF_OPC_FENCE   7'b0001111
`define SHUF_OPC_SYSTEM  7'b1110011  // ecall/ebreak when funct3 is zero, csr otherwise
`define SHUF_OPC_LOAD    7'b0000011
`define SHUF_OPC_STORE   7'b0100011
`define SHUF_OPC_LUI     7'b0110111
`define SHUF_OPC_AUIPC   7'b0010111
`define SHUF_OPC_OP      7'b0110011  // r-type alu ops

// pick lfsr, galois form of x^16 + x^14 + x^13 + x^11 + 1
`define SHUF_LFSR_SEED   16'hace1
`define SHUF_LFSR_TAPS   16'hb400

`endif
